//--- rtl/conv_geom_pkg.sv
`default_nettype none
// ############################
// conv geometry package
// lane, beat, group and coordinate sizes
// ############################

package conv_geom_pkg;

    // mac array and data widths
    localparam int LANES      = 64;
    localparam int LANE_IW    = $clog2(LANES);
    localparam int PIX_W      = 8;
    localparam int WORD_PIX   = 8;
    localparam int MAX_GROUPS = 8;
    localparam int SUM_W      = 32;
    localparam int COORD_W    = 13;
    // kernel area up to 64 needs 7 bits
    localparam int AREA_W     = 7;
    localparam int GRP_W      = $clog2(MAX_GROUPS + 1);

    typedef logic [PIX_W-1:0] pixel_t;
    // one beat, pixel 0 in the low byte
    typedef pixel_t [WORD_PIX-1:0] beat_word_t;
    typedef pixel_t [LANES-1:0] lane_vec_t;
    typedef logic [MAX_GROUPS-1:0][SUM_W-1:0] sum_vec_t;
    typedef logic [COORD_W-1:0] coord_t;
    typedef logic [GRP_W-1:0] group_cnt_t;

endpackage
`default_nettype wire

//--- rtl/conv_ctrl_pkg.sv
`default_nettype none
// ############################
// conv control package
// sequencer states and kernel limits
// ############################

package conv_ctrl_pkg;

    // widest kernel row handled in one beat
    localparam int MAX_KER_COL = 8;

    // holds a sampled kernel width, 0 to 8
    typedef logic [$clog2(MAX_KER_COL + 1)-1:0] kcol_t;

    // idle until start, then fetch kernel rows
    typedef enum logic [0:0] {
        SEQ_IDLE,
        SEQ_FETCH
    } seq_state_t;

endpackage
`default_nettype wire

//--- rtl/batch_if.sv
`timescale 1ns/1ps
`default_nettype none
// ############################
// batch interface
// packed lanes and tags, loader to mac and tagger
// ############################

interface batch_if import conv_geom_pkg::*; ();

    // one-cycle strobe per completed batch
    logic                batch_valid;
    lane_vec_t           data_lanes;
    lane_vec_t           weight_lanes;
    group_cnt_t          group_cnt;
    // kernel area, lanes per group
    logic [AREA_W-1:0]   area;
    // position of group 0
    coord_t              out_row;
    coord_t              out_col;
    logic                last;

    modport loader (
        output batch_valid, data_lanes, weight_lanes, group_cnt, area,
        output out_row, out_col, last
    );

    modport mac (
        input batch_valid, data_lanes, weight_lanes, group_cnt, area
    );

    modport tagger (
        input batch_valid, group_cnt, out_row, out_col, last
    );

endinterface
`default_nettype wire

//--- rtl/window_sequencer.sv
`timescale 1ns/1ps
`default_nettype none
// ############################
// window sequencer
// kernel-row and output-position walk
// group count per batch
// ############################

module window_sequencer
    import conv_geom_pkg::*;
    import conv_ctrl_pkg::*;
(
    input  logic       clk,
    input  logic       rst,
    input  logic       start_i,
    input  logic       beat_i,
    input  coord_t     img_rows_i,
    input  coord_t     img_cols_i,
    input  coord_t     ker_rows_i,
    input  coord_t     ker_cols_i,
    output logic       busy_o,
    output logic       beat_take_o,
    output coord_t     ker_idx_o,
    output logic       batch_end_o,
    output group_cnt_t group_cnt_o,
    output coord_t     out_row_o,
    output coord_t     out_col_o,
    output logic       last_o,
    output coord_t     req_row_o,
    output coord_t     req_col_o
);
    seq_state_t        state_q;
    coord_t            rows_q, cols_q, krows_q;
    kcol_t             kcols_q;
    coord_t            ker_idx_q, out_row_q, out_col_q;
    coord_t            out_rows, out_cols, left;
    logic [AREA_W-1:0] area;
    group_cnt_t        cap, fetch, grp;
    logic              row_end;

    // output map size
    assign out_rows = rows_q - krows_q + coord_t'(1);
    assign out_cols = cols_q - coord_t'(kcols_q) + coord_t'(1);
    assign area     = AREA_W'(krows_q * coord_t'(kcols_q));
    // groups that fit into one 8-pixel fetch
    assign fetch    = group_cnt_t'(WORD_PIX + 1) - group_cnt_t'(kcols_q);
    // columns left in this output row
    assign left     = out_cols - out_col_q;

    always_comb begin
        // lane capacity, largest g with g*area <= 64
        cap = '0;
        for (int g = 1; g <= MAX_GROUPS; g++) begin
            if (g * int'(area) <= LANES) begin
                cap = group_cnt_t'(g);
            end
        end
        grp = (fetch < cap) ? fetch : cap;
        // clip at row end
        if (coord_t'(grp) > left) begin
            grp = group_cnt_t'(left);
        end
    end

    assign busy_o      = (state_q == SEQ_FETCH);
    assign beat_take_o = beat_i && (state_q == SEQ_FETCH);
    assign batch_end_o = beat_take_o && (ker_idx_q == krows_q - coord_t'(1));
    assign row_end     = (out_col_q + coord_t'(grp)) >= out_cols;
    // this batch closes the frame
    assign last_o      = row_end && (out_row_q == out_rows - coord_t'(1));
    assign ker_idx_o   = ker_idx_q;
    assign group_cnt_o = grp;
    assign out_row_o   = out_row_q;
    assign out_col_o   = out_col_q;
    // image row needed by the next beat
    assign req_row_o   = out_row_q + ker_idx_q;
    assign req_col_o   = out_col_q;

    always_ff @(posedge clk) begin
        if (!rst) begin
            state_q   <= SEQ_IDLE;
            rows_q    <= '0;
            cols_q    <= '0;
            krows_q   <= '0;
            kcols_q   <= '0;
            ker_idx_q <= '0;
            out_row_q <= '0;
            out_col_q <= '0;
        end else if (state_q == SEQ_IDLE) begin
            if (start_i) begin
                state_q   <= SEQ_FETCH;
                rows_q    <= img_rows_i;
                cols_q    <= img_cols_i;
                krows_q   <= ker_rows_i;
                kcols_q   <= kcol_t'(ker_cols_i);
                ker_idx_q <= '0;
                out_row_q <= '0;
                out_col_q <= '0;
            end
        end else if (beat_take_o) begin
            if (batch_end_o) begin
                ker_idx_q <= '0;
                if (last_o) begin
                    state_q <= SEQ_IDLE;
                end else if (row_end) begin
                    // wrap to next output row
                    out_col_q <= '0;
                    out_row_q <= out_row_q + coord_t'(1);
                end else begin
                    out_col_q <= out_col_q + coord_t'(grp);
                end
            end else begin
                ker_idx_q <= ker_idx_q + coord_t'(1);
            end
        end
    end

endmodule
`default_nettype wire

//--- rtl/window_loader.sv
`timescale 1ns/1ps
`default_nettype none
// ############################
// window loader
// packs beat pixels and weights into the mac lanes
// ############################

module window_loader
    import conv_geom_pkg::*;
(
    input  logic       clk,
    input  logic       rst,
    input  logic       beat_take_i,
    input  coord_t     ker_idx_i,
    input  logic       batch_end_i,
    input  coord_t     ker_rows_i,
    input  coord_t     ker_cols_i,
    input  group_cnt_t group_cnt_i,
    input  coord_t     out_row_i,
    input  coord_t     out_col_i,
    input  logic       last_i,
    input  beat_word_t pixel_word_i,
    input  beat_word_t weight_word_i,
    batch_if.loader    bif
);
    lane_vec_t         data_q, weight_q;
    lane_vec_t         data_nxt, weight_nxt;
    logic [AREA_W-1:0] area;
    logic              valid_q;

    assign area = AREA_W'(ker_rows_i * ker_cols_i);

    always_comb begin
        int idx;
        // first kernel row starts from empty lanes
        data_nxt   = (ker_idx_i == '0) ? '0 : data_q;
        weight_nxt = (ker_idx_i == '0) ? '0 : weight_q;
        for (int g = 0; g < MAX_GROUPS; g++) begin
            for (int i = 0; i < WORD_PIX; i++) begin
                idx = g * int'(area) + int'(ker_idx_i) * int'(ker_cols_i) + i;
                if (g < int'(group_cnt_i) && i < int'(ker_cols_i) &&
                    (g + i) < WORD_PIX && idx < LANES) begin
                    // group g sees the window shifted by g pixels
                    data_nxt[idx[LANE_IW-1:0]]   = pixel_word_i[g + i];
                    // same weight row for every group
                    weight_nxt[idx[LANE_IW-1:0]] = weight_word_i[i];
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (beat_take_i) begin
            data_q   <= data_nxt;
            weight_q <= weight_nxt;
        end
    end

    // batch tags, latched with the closing beat
    always_ff @(posedge clk) begin
        if (beat_take_i && batch_end_i) begin
            bif.group_cnt <= group_cnt_i;
            bif.area      <= area;
            bif.out_row   <= out_row_i;
            bif.out_col   <= out_col_i;
            bif.last      <= last_i;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst) begin
            valid_q <= 1'b0;
        end else begin
            valid_q <= beat_take_i && batch_end_i;
        end
    end

    assign bif.batch_valid  = valid_q;
    assign bif.data_lanes   = data_q;
    assign bif.weight_lanes = weight_q;

endmodule
`default_nettype wire

//--- rtl/group_mac.sv
`timescale 1ns/1ps
`default_nettype none
// ############################
// group mac
// lane products, then one sum per group
// ############################

module group_mac
    import conv_geom_pkg::*;
(
    input  logic     clk,
    input  logic     rst,
    batch_if.mac     bif,
    output sum_vec_t sums_o,
    output logic     sums_valid_o
);
    // unsigned 8x8 products
    logic [2*PIX_W-1:0] prod_q [LANES];
    logic               valid1_q;
    group_cnt_t         grp1_q;
    logic [AREA_W-1:0]  area1_q;
    sum_vec_t           sum_nxt;

    // stage 1
    always_ff @(posedge clk) begin
        if (bif.batch_valid) begin
            for (int l = 0; l < LANES; l++) begin
                prod_q[l] <= (2*PIX_W)'(bif.data_lanes[l]) * (2*PIX_W)'(bif.weight_lanes[l]);
            end
            grp1_q  <= bif.group_cnt;
            area1_q <= bif.area;
        end
    end

    // group g owns lanes g*area up to (g+1)*area-1
    always_comb begin
        int lo;
        sum_nxt = '0;
        for (int g = 0; g < MAX_GROUPS; g++) begin
            lo = g * int'(area1_q);
            for (int l = 0; l < LANES; l++) begin
                // unused groups stay zero
                if (g < int'(grp1_q) && l >= lo && l < lo + int'(area1_q)) begin
                    sum_nxt[g] = sum_nxt[g] + SUM_W'(prod_q[l]);
                end
            end
        end
    end

    // stage 2
    always_ff @(posedge clk) begin
        if (valid1_q) begin
            sums_o <= sum_nxt;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst) begin
            valid1_q     <= 1'b0;
            sums_valid_o <= 1'b0;
        end else begin
            valid1_q     <= bif.batch_valid;
            sums_valid_o <= valid1_q;
        end
    end

endmodule
`default_nettype wire

//--- rtl/result_tagger.sv
`timescale 1ns/1ps
`default_nettype none
// ############################
// result tagger
// position tags in step with the mac
// registered result outputs
// ############################

module result_tagger
    import conv_geom_pkg::*;
(
    input  logic       clk,
    input  logic       rst,
    batch_if.tagger    bif,
    input  sum_vec_t   sums_i,
    input  logic       sums_valid_i,
    output sum_vec_t   result_o,
    output logic       result_valid_o,
    output coord_t     result_row_o,
    output coord_t     result_col_o,
    output group_cnt_t result_count_o,
    output logic       result_last_o
);
    // two tag stages, matching the two mac stages
    group_cnt_t grp_q [2];
    coord_t     row_q [2];
    coord_t     col_q [2];
    logic       last_q [2];

    always_ff @(posedge clk) begin
        grp_q[0]  <= bif.group_cnt;
        row_q[0]  <= bif.out_row;
        col_q[0]  <= bif.out_col;
        last_q[0] <= bif.last;
        grp_q[1]  <= grp_q[0];
        row_q[1]  <= row_q[0];
        col_q[1]  <= col_q[0];
        last_q[1] <= last_q[0];
        if (sums_valid_i) begin
            result_o       <= sums_i;
            result_row_o   <= row_q[1];
            result_col_o   <= col_q[1];
            result_count_o <= grp_q[1];
        end
    end

    always_ff @(posedge clk) begin
        if (!rst) begin
            result_valid_o <= 1'b0;
            result_last_o  <= 1'b0;
        end else begin
            result_valid_o <= sums_valid_i;
            result_last_o  <= sums_valid_i && last_q[1];
        end
    end

endmodule
`default_nettype wire

//--- rtl/conv_top.sv
`timescale 1ns/1ps
`default_nettype none
// ############################
// conv top
// window packer with grouped mac
// ############################

module conv_top
    import conv_geom_pkg::*;
(
    input  logic       clk,
    input  logic       rst,
    input  logic       start_i,
    input  coord_t     img_rows_i,
    input  coord_t     img_cols_i,
    input  coord_t     ker_rows_i,
    input  coord_t     ker_cols_i,
    input  logic       beat_i,
    input  beat_word_t pixel_word_i,
    input  beat_word_t weight_word_i,
    output logic       busy_o,
    output coord_t     req_row_o,
    output coord_t     req_col_o,
    output sum_vec_t   result_o,
    output logic       result_valid_o,
    output coord_t     result_row_o,
    output coord_t     result_col_o,
    output group_cnt_t result_count_o,
    output logic       result_last_o
);
    // sequencer to loader
    logic       beat_take, batch_end, last;
    coord_t     ker_idx, out_row, out_col;
    group_cnt_t group_cnt;
    // mac to tagger
    sum_vec_t   sums;
    logic       sums_valid;

    batch_if bif ();

    window_sequencer u_seq (
        .clk         (clk),
        .rst         (rst),
        .start_i     (start_i),
        .beat_i      (beat_i),
        .img_rows_i  (img_rows_i),
        .img_cols_i  (img_cols_i),
        .ker_rows_i  (ker_rows_i),
        .ker_cols_i  (ker_cols_i),
        .busy_o      (busy_o),
        .beat_take_o (beat_take),
        .ker_idx_o   (ker_idx),
        .batch_end_o (batch_end),
        .group_cnt_o (group_cnt),
        .out_row_o   (out_row),
        .out_col_o   (out_col),
        .last_o      (last),
        .req_row_o   (req_row_o),
        .req_col_o   (req_col_o)
    );

    window_loader u_load (
        .clk           (clk),
        .rst           (rst),
        .beat_take_i   (beat_take),
        .ker_idx_i     (ker_idx),
        .batch_end_i   (batch_end),
        .ker_rows_i    (ker_rows_i),
        .ker_cols_i    (ker_cols_i),
        .group_cnt_i   (group_cnt),
        .out_row_i     (out_row),
        .out_col_i     (out_col),
        .last_i        (last),
        .pixel_word_i  (pixel_word_i),
        .weight_word_i (weight_word_i),
        .bif           (bif)
    );

    group_mac u_mac (
        .clk          (clk),
        .rst          (rst),
        .bif          (bif),
        .sums_o       (sums),
        .sums_valid_o (sums_valid)
    );

    result_tagger u_tag (
        .clk            (clk),
        .rst            (rst),
        .bif            (bif),
        .sums_i         (sums),
        .sums_valid_i   (sums_valid),
        .result_o       (result_o),
        .result_valid_o (result_valid_o),
        .result_row_o   (result_row_o),
        .result_col_o   (result_col_o),
        .result_count_o (result_count_o),
        .result_last_o  (result_last_o)
    );

endmodule
`default_nettype wire

//--- tests/conv_properties.sv
`timescale 1ns/1ps
`default_nettype none
// ############################
// conv properties
// result flags and mac latency
// ############################

module conv_properties
    import conv_geom_pkg::*;
(
    input logic       clk,
    input logic       rst,
    input logic       batch_valid,
    input logic       result_valid,
    input logic       result_last,
    input group_cnt_t result_count
);
    // number of assertion failures so far
    int fail_cnt = 0;

    // a result carries at least one group, never more than the lanes allow
    count_range: assert property (@(posedge clk) disable iff (!rst)
        result_valid |-> (result_count >= group_cnt_t'(1) &&
                          result_count <= group_cnt_t'(MAX_GROUPS)))
    else begin
        fail_cnt++;
        $error("result_count_o out of range: %0d", result_count);
    end

    // last flag only on a valid result
    last_with_valid: assert property (@(posedge clk) disable iff (!rst)
        result_last |-> result_valid)
    else begin
        fail_cnt++;
        $error("result_last_o without result_valid_o");
    end

    // two mac stages plus the output register
    batch_latency: assert property (@(posedge clk) disable iff (!rst)
        result_valid == $past(batch_valid, 3))
    else begin
        fail_cnt++;
        $error("result_valid_o not 3 cycles after batch_valid");
    end

endmodule

bind conv_top conv_properties u_props (
    .clk          (clk),
    .rst          (rst),
    .batch_valid  (bif.batch_valid),
    .result_valid (result_valid_o),
    .result_last  (result_last_o),
    .result_count (result_count_o)
);
`default_nettype wire

//--- tests/tb_conv.sv
`timescale 1ns/1ps
`default_nettype none
// ############################
// conv testbench
// random frames against a reference dot product
// ############################

module tb_conv
    import conv_geom_pkg::*;
();
    // expected batch, due is the cycle its result must show up
    typedef struct packed {
        coord_t     row;
        coord_t     col;
        group_cnt_t cnt;
        logic       last;
        int         due;
    } exp_t;

    logic       clk, rst, start_i, beat_i;
    coord_t     img_rows_i, img_cols_i, ker_rows_i, ker_cols_i;
    beat_word_t pixel_word_i, weight_word_i;
    logic       busy_o, result_valid_o, result_last_o;
    coord_t     req_row_o, req_col_o, result_row_o, result_col_o;
    sum_vec_t   result_o;
    group_cnt_t result_count_o;

    pixel_t img [16][16];
    pixel_t ker [8][8];
    int     f_rows, f_cols, f_kr, f_kc;
    exp_t   exp_q [$];
    int     cyc = 0;
    int     errors = 0;

    conv_top uut (.*);

    always #2 clk = ~clk;

    always @(posedge clk) begin
        cyc <= cyc + 1;
    end

    // window dot product straight from the stored image and kernel
    function automatic logic [SUM_W-1:0] window_dot(input int orow, input int ocol);
        logic [SUM_W-1:0] acc;
        acc = '0;
        for (int r = 0; r < f_kr; r++) begin
            for (int i = 0; i < f_kc; i++) begin
                acc = acc + SUM_W'(img[orow + r][ocol + i]) * SUM_W'(ker[r][i]);
            end
        end
        return acc;
    endfunction

    // min of lane capacity, fetch width and columns left
    function automatic int predict_groups(input int ocol);
        int cnt;
        cnt = LANES / (f_kr * f_kc);
        if (WORD_PIX - f_kc + 1 < cnt) begin
            cnt = WORD_PIX - f_kc + 1;
        end
        if (f_cols - f_kc + 1 - ocol < cnt) begin
            cnt = f_cols - f_kc + 1 - ocol;
        end
        return cnt;
    endfunction

    task automatic next_cycle();
        @(posedge clk);
        #1;
    endtask

    task automatic fill_random();
        for (int r = 0; r < 16; r++) begin
            for (int c = 0; c < 16; c++) begin
                img[r][c] = pixel_t'($urandom);
            end
        end
        for (int r = 0; r < 8; r++) begin
            for (int c = 0; c < 8; c++) begin
                ker[r][c] = pixel_t'($urandom);
            end
        end
    endtask

    task automatic wait_drain();
        int waited;
        waited = 0;
        while (exp_q.size() != 0 && waited < 50) begin
            next_cycle();
            waited++;
        end
        if (exp_q.size() != 0) begin
            $display("timeout: %0d results still missing after 50 cycles", exp_q.size());
            errors++;
            exp_q.delete();
        end
    endtask

    // one whole frame, batch by batch in raster order
    task automatic run_frame(input int rows, input int cols, input int kr, input int kc,
                             input bit gaps);
        int   orow, ocol, cnt;
        bit   last;
        exp_t e;
        f_rows = rows;
        f_cols = cols;
        f_kr = kr;
        f_kc = kc;
        img_rows_i = coord_t'(rows);
        img_cols_i = coord_t'(cols);
        ker_rows_i = coord_t'(kr);
        ker_cols_i = coord_t'(kc);
        start_i = 1'b1;
        next_cycle();
        start_i = 1'b0;
        orow = 0;
        ocol = 0;
        last = 1'b0;
        while (!last) begin
            cnt = predict_groups(ocol);
            last = (ocol + cnt >= cols - kc + 1) && (orow == rows - kr);
            for (int r = 0; r < kr; r++) begin
                // optional idle cycle between beats
                if (gaps && $urandom_range(1, 0) == 1) begin
                    next_cycle();
                end
                if (busy_o !== 1'b1) begin
                    $display("busy_o low in the middle of a frame at cycle %0d", cyc);
                    errors++;
                end
                if (req_row_o !== coord_t'(orow + r)) begin
                    $display("CHECK FAILED req_row_o: got %h expected %h", req_row_o,
                             coord_t'(orow + r));
                    errors++;
                end
                if (req_col_o !== coord_t'(ocol)) begin
                    $display("CHECK FAILED req_col_o: got %h expected %h", req_col_o,
                             coord_t'(ocol));
                    errors++;
                end
                for (int k = 0; k < WORD_PIX; k++) begin
                    pixel_word_i[k] = (ocol + k < cols) ? img[orow + r][ocol + k] : '0;
                    // weights past the kernel width are junk
                    weight_word_i[k] = (k < kc) ? ker[r][k] : pixel_t'($urandom);
                end
                beat_i = 1'b1;
                if (r == kr - 1) begin
                    e.row = coord_t'(orow);
                    e.col = coord_t'(ocol);
                    e.cnt = group_cnt_t'(cnt);
                    e.last = last;
                    e.due = cyc + 4;
                    exp_q.push_back(e);
                end
                next_cycle();
                beat_i = 1'b0;
            end
            ocol = ocol + cnt;
            if (ocol >= cols - kc + 1) begin
                ocol = 0;
                orow++;
            end
        end
        if (busy_o !== 1'b0) begin
            $display("busy_o still high one cycle after the last batch");
            errors++;
        end
        wait_drain();
    endtask

    // beats with no frame running must be dropped
    task automatic idle_beats();
        coord_t row0, col0;
        row0 = req_row_o;
        col0 = req_col_o;
        for (int n = 0; n < 6; n++) begin
            pixel_word_i = {$urandom, $urandom};
            weight_word_i = {$urandom, $urandom};
            beat_i = 1'b1;
            next_cycle();
        end
        beat_i = 1'b0;
        repeat (8) next_cycle();
        if (busy_o !== 1'b0 || req_row_o !== row0 || req_col_o !== col0) begin
            $display("idle beats changed busy_o or the request position");
            errors++;
        end
    endtask

    // compare every result against the head of the queue
    always @(negedge clk) begin
        exp_t             e;
        logic [SUM_W-1:0] want;
        if (result_valid_o === 1'b1) begin
            if (exp_q.size() == 0) begin
                $display("result at cycle %0d with no batch pending", cyc);
                errors++;
            end else begin
                e = exp_q.pop_front();
                if (cyc != e.due) begin
                    $display("CHECK FAILED result_valid_o cycle: got %h expected %h", cyc, e.due);
                    errors++;
                end
                if (result_row_o !== e.row || result_col_o !== e.col) begin
                    $display("CHECK FAILED result_row_o/result_col_o: got %h/%h expected %h/%h",
                             result_row_o, result_col_o, e.row, e.col);
                    errors++;
                end
                if (result_count_o !== e.cnt) begin
                    $display("CHECK FAILED result_count_o: got %h expected %h",
                             result_count_o, e.cnt);
                    errors++;
                end
                if (result_last_o !== e.last) begin
                    $display("CHECK FAILED result_last_o: got %h expected %h",
                             result_last_o, e.last);
                    errors++;
                end
                for (int g = 0; g < MAX_GROUPS; g++) begin
                    // groups past the count must read zero
                    want = (g < int'(e.cnt)) ? window_dot(int'(e.row), int'(e.col) + g) : '0;
                    if (result_o[g] !== want) begin
                        $display("CHECK FAILED result_o[%0d]: got %h expected %h", g,
                                 result_o[g], want);
                        errors++;
                    end
                end
            end
        end
    end

    initial begin
        #100000;
        $display("run stopped by the watchdog, simulation took too long");
        $display("Verification failed");
        $finish;
    end

    initial begin
        void'($urandom(26));
        clk = 1'b0;
        rst = 1'b0;
        start_i = 1'b0;
        beat_i = 1'b0;
        img_rows_i = '0;
        img_cols_i = '0;
        ker_rows_i = '0;
        ker_cols_i = '0;
        pixel_word_i = '0;
        weight_word_i = '0;
        repeat (10) @(posedge clk);
        #1;
        rst = 1'b1;
        // nothing may come out before the first start
        repeat (5) next_cycle();
        fill_random();
        run_frame(8, 10, 3, 3, 1'b1);
        // 1x1 kernel, a batch every cycle
        run_frame(3, 12, 1, 1, 1'b0);
        // full lanes, one group per batch
        run_frame(8, 9, 8, 8, 1'b0);
        idle_beats();
        fill_random();
        run_frame(5, 7, 2, 4, 1'b1);
        errors = errors + uut.u_props.fail_cnt;
        $display("tb_conv finished with %0d errors", errors);
        if (errors == 0) begin
            $display("Verification passed");
        end else begin
            $display("Verification failed");
        end
        $finish;
    end

endmodule
`default_nettype wire

//--- list.f
rtl/conv_geom_pkg.sv
rtl/conv_ctrl_pkg.sv
rtl/batch_if.sv
rtl/window_sequencer.sv
rtl/window_loader.sv
rtl/group_mac.sv
rtl/result_tagger.sv
rtl/conv_top.sv
tests/conv_properties.sv
tests/tb_conv.sv

//--- run.sh
#!/usr/bin/env bash
# build the conv testbench with verilator, run it, look for the pass line
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert --timescale 1ns/1ps --top-module tb_conv -f list.f &&
    out="$(./obj_dir/Vtb_conv +verilator+error+limit+100)" ;
printf '%s\n' "$out" &&
    printf '%s\n' "$out" | grep -qx "Verification passed" ||
    { echo "simulation run did not pass"; exit 1; }
